// File: vlog.f
hdl/serial_bus_pkg.sv
hdl/slave_in_port.sv
hdl/slave_mem.sv
hdl/slave_out_port.sv
hdl/serial_slave.sv
test/serial_slave_tb.sv

// File: test/serial_slave_tb.sv
// Serial bus slave testbench.
// Acts as a serial master that sends write and read bursts, keeps a
// reference copy of the memory, and checks each returned byte and the
// framing on slave_ready, tx_valid and tx_last.

`timescale 1ns/1ns
`default_nettype none

module serial_slave_tb
	import serial_bus_pkg::*;
();

	localparam int TIMEOUT  = 60;
	localparam int WIN_BASE = 12'h400;

	logic               clk;
	logic               reset;
	logic               master_valid;
	logic               read_en;
	logic               write_en;
	logic [BURST_W-1:0] burst;
	logic               rx_address;
	logic               rx_data;
	logic               slave_ready;
	logic               tx_data;
	logic               tx_valid;
	logic               tx_last;

	logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
	logic [DATA_W-1:0] wr_bytes [16];
	int                seed;
	int                errors;
	int                tests;
	int                valid_run;
	logic              poke_busy;
	string             hang_msg;
	event              run_hung;

	serial_slave i_dut
	(
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.burst        (burst),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.tx_last      (tx_last)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Number of consecutive cycles that tx_valid has been high so far.
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_run <= 0;
		else if (tx_valid)
			valid_run <= valid_run + 1;
		else
			valid_run <= 0;
	end

	// A handshake with exactly one enable set takes slave_ready low.
	assert property (@(posedge clk) disable iff (reset)
		(master_valid && slave_ready && (read_en != write_en)) |=> !slave_ready)
	else
	begin
		errors++;
		$display("Error at %0t ns: slave_ready stayed high after a handshake", $time);
	end

	assert property (@(posedge clk) disable iff (reset) valid_run <= DATA_W)
	else
	begin
		errors++;
		$display("Error at %0t ns: tx_valid high for more than 8 cycles", $time);
	end

	// tx_last only ever marks the eighth bit of a byte.
	assert property (@(posedge clk) disable iff (reset)
		tx_last |-> (tx_valid && (valid_run == DATA_W - 1)))
	else
	begin
		errors++;
		$display("Error at %0t ns: tx_last outside the final bit of a byte", $time);
	end

	initial
	begin
		@(run_hung);
		$display("%s", hang_msg);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic stop_on_timeout(input string msg);
		hang_msg = msg;
		-> run_hung;
		forever @(posedge clk);
	endtask

	task automatic clear_inputs();
		master_valid = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
	endtask

	task automatic fill_bytes();
		for (int i = 0; i < 16; i++)
			wr_bytes[i] = DATA_W'($random(seed));
	endtask

	// Moves to the next falling edge, then waits there for slave_ready.
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		clear_inputs();
		while (!slave_ready)
		begin
			if (n == TIMEOUT)
				stop_on_timeout("Timed out waiting for slave_ready to go high.");
			@(negedge clk);
			n++;
		end
	endtask

	// Handshake with address bit 0, then address bits 1 to 11. The first
	// write byte rides along on rx_data.
	task automatic send_header(input bus_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [BURST_W-1:0] blen);
		wait_ready();
		master_valid = 1'b1;
		write_en     = (op == OP_WRITE);
		read_en      = (op == OP_READ);
		burst        = blen;
		rx_address   = addr[0];
		rx_data      = wr_bytes[0][0];
		for (int i = 1; i < ADDR_W; i++)
		begin
			@(negedge clk);
			master_valid = poke_busy;
			read_en      = poke_busy;
			write_en     = 1'b0;
			rx_address   = addr[i];
			rx_data      = (i < DATA_W) ? wr_bytes[0][i] : 1'b0;
		end
	endtask

	task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [BURST_W-1:0] blen);
		send_header(OP_WRITE, addr, blen);
		ref_mem[addr] = wr_bytes[0];
		for (int b = 1; b <= int'(blen); b++)
		begin
			wait_ready();
			master_valid = 1'b1;
			write_en     = 1'b1;
			rx_data      = wr_bytes[b][0];
			for (int i = 1; i < DATA_W; i++)
			begin
				@(negedge clk);
				master_valid = 1'b0;
				write_en     = 1'b0;
				rx_data      = wr_bytes[b][i];
			end
			ref_mem[addr + ADDR_W'(b)] = wr_bytes[b];
		end
	endtask

	task automatic check_byte(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got);
		assert (got === ref_mem[addr])
		else
		begin
			errors++;
			$display("Error at %0t ns: address %03h expected %02h, got %02h",
				$time, addr, ref_mem[addr], got);
		end
	endtask

	// Gathers tx bits into bytes until tx_last or the expected count.
	task automatic collect_read(input logic [ADDR_W-1:0] addr, input int beats);
		logic [DATA_W-1:0] got;
		int                nbytes;
		int                nbits;
		int                idle;
		logic              done;
		got    = '0;
		nbytes = 0;
		nbits  = 0;
		idle   = 0;
		done   = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			clear_inputs();
			if (tx_valid)
			begin
				idle       = 0;
				got[nbits] = tx_data;
				if (nbits == DATA_W - 1)
				begin
					check_byte(addr + ADDR_W'(nbytes), got);
					assert (tx_last == (nbytes == beats - 1))
					else
					begin
						errors++;
						$display("Error at %0t ns: tx_last is %0b on byte %0d of %0d",
							$time, tx_last, nbytes + 1, beats);
					end
					nbytes++;
					nbits = 0;
					done  = tx_last || (nbytes == beats);
				end
				else
				begin
					nbits++;
				end
			end
			else
			begin
				idle++;
				if (idle == TIMEOUT)
					stop_on_timeout("Timed out waiting for read data on tx_valid.");
			end
		end
		assert (nbytes == beats)
		else
		begin
			errors++;
			$display("Error at %0t ns: read returned %0d bytes, expected %0d",
				$time, nbytes, beats);
		end
	endtask

	task automatic send_read(input logic [ADDR_W-1:0] addr, input logic [BURST_W-1:0] blen);
		send_header(OP_READ, addr, blen);
		collect_read(addr, int'(blen) + 1);
	endtask

	// Holds master_valid for a whole header with both or neither enable set.
	task automatic send_invalid(input logic both);
		wait_ready();
		for (int i = 0; i < ADDR_W; i++)
		begin
			master_valid = 1'b1;
			read_en      = both;
			write_en     = both;
			burst        = BURST_W'($random(seed));
			rx_address   = 1'($random(seed));
			rx_data      = 1'($random(seed));
			@(negedge clk);
			assert (slave_ready && !tx_valid)
			else
			begin
				errors++;
				$display("Error at %0t ns: an invalid request was accepted", $time);
			end
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("Test %0d, %s: ok", tests, name);
		else
			$display("Test %0d, %s: %0d errors", tests, name, errors - errors_before);
	endtask

	initial
	begin
		int                 err0;
		logic [ADDR_W-1:0]  base;
		logic [BURST_W-1:0] blen;
		seed      = 32'h3968dfa7;
		errors    = 0;
		tests     = 0;
		poke_busy = 1'b0;
		reset     = 1'b1;
		burst     = '0;
		clear_inputs();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err0 = errors;
		@(negedge clk);
		assert (slave_ready && !tx_valid && !tx_last)
		else
		begin
			errors++;
			$display("Error at %0t ns: outputs not in their reset state", $time);
		end
		end_test("reset state", err0);

		err0 = errors;
		fill_bytes();
		send_write(12'h123, 4'd0);
		send_read(12'h123, 4'd0);
		end_test("single write and read", err0);

		err0 = errors;
		base = ADDR_W'($random(seed));
		blen = BURST_W'($random(seed));
		fill_bytes();
		send_write(base, blen);
		send_read(base, blen);
		end_test("burst write and read", err0);

		// Four bytes from 4094 wrap round to addresses 0 and 1.
		err0 = errors;
		fill_bytes();
		send_write(12'hffe, 4'd3);
		for (int i = 0; i < 4; i++)
			send_read(12'hffe + ADDR_W'(i), 4'd0);
		end_test("address wrap", err0);

		err0 = errors;
		fill_bytes();
		send_write(12'h200, 4'd1);
		poke_busy = 1'b1;
		fill_bytes();
		send_write(12'h300, 4'd0);
		send_read(12'h200, 4'd1);
		poke_busy = 1'b0;
		send_invalid(1'b1);
		send_invalid(1'b0);
		send_read(12'h200, 4'd1);
		send_read(12'h300, 4'd0);
		end_test("busy and invalid requests", err0);

		// Random traffic stays inside a 64 byte window that is filled first.
		err0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			fill_bytes();
			send_write(WIN_BASE + ADDR_W'(16 * i), 4'd15);
		end
		for (int i = 0; i < 24; i++)
		begin
			base = WIN_BASE + ADDR_W'(6'($random(seed)) % 48);
			blen = BURST_W'($random(seed));
			fill_bytes();
			if (1'($random(seed)))
				send_write(base, blen);
			else
				send_read(base, blen);
		end
		end_test("random traffic", err0);

		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/serial_slave.sv
// Serial bus slave top level.
// Chains the receiver, the memory stage and the transmitter, and returns
// the transmitter busy flag to the receiver for read pacing.

`timescale 1ns/1ns
`default_nettype none

module serial_slave
	import serial_bus_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               master_valid,
	input  logic               read_en,
	input  logic               write_en,
	input  logic [BURST_W-1:0] burst,
	input  logic               rx_address,
	input  logic               rx_data,
	output logic               slave_ready,
	output logic               tx_data,
	output logic               tx_valid,
	output logic               tx_last
);

	mem_req_t mem_req;
	logic     req_valid;
	logic     req_last;
	rd_beat_t rd_beat;
	logic     beat_valid;
	logic     out_busy;

	slave_in_port i_in_port
	(
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.burst        (burst),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.out_busy     (out_busy),
		.slave_ready  (slave_ready),
		.mem_req      (mem_req),
		.req_valid    (req_valid),
		.req_last     (req_last)
	);

	slave_mem i_mem
	(
		.clk        (clk),
		.reset      (reset),
		.mem_req    (mem_req),
		.req_valid  (req_valid),
		.req_last   (req_last),
		.rd_beat    (rd_beat),
		.beat_valid (beat_valid)
	);

	slave_out_port i_out_port
	(
		.clk        (clk),
		.reset      (reset),
		.rd_beat    (rd_beat),
		.beat_valid (beat_valid),
		.tx_data    (tx_data),
		.tx_valid   (tx_valid),
		.tx_last    (tx_last),
		.out_busy   (out_busy)
	);

endmodule

`default_nettype wire

// File: hdl/slave_out_port.sv
// Serial bus slave transmitter.
// Loads each read byte into a shift register and sends it LSB first over
// eight cycles, framed by tx_valid and with tx_last on the final bit of a
// burst. Reports busy back to the receiver while a byte is in flight.

`timescale 1ns/1ns
`default_nettype none

module slave_out_port
	import serial_bus_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  rd_beat_t rd_beat,
	input  logic     beat_valid,
	output logic     tx_data,
	output logic     tx_valid,
	output logic     tx_last,
	output logic     out_busy
);

	tx_state_e         state;
	logic [2:0]        bit_cnt;
	logic [DATA_W-1:0] shift_q;
	logic              last_q;
	logic              final_bit;

	assign final_bit = (bit_cnt == 3'(DATA_W - 1));

	assign tx_valid = (state == TX_SHIFT);
	assign tx_data  = tx_valid && shift_q[0];
	assign tx_last  = tx_valid && last_q && final_bit;

	// Busy starts on the load cycle so the receiver never issues into it.
	assign out_busy = beat_valid || (state == TX_SHIFT);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
			last_q  <= 1'b0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (beat_valid)
					begin
						bit_cnt <= '0;
						last_q  <= rd_beat.last;
						state   <= TX_SHIFT;
					end
				end
				TX_SHIFT:
				begin
					bit_cnt <= bit_cnt + 3'd1;
					if (final_bit)
						state <= TX_IDLE;
				end
				default:
				begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// Byte shifter.
	always_ff @(posedge clk)
	begin
		if ((state == TX_IDLE) && beat_valid)
			shift_q <= rd_beat.data;
		else if (state == TX_SHIFT)
			shift_q <= {1'b0, shift_q[DATA_W-1:1]};
	end

endmodule

`default_nettype wire

// File: hdl/slave_mem.sv
// Serial bus slave memory stage.
// A 4096 byte array with byte writes and registered reads. Each read
// returns its byte one cycle after the request, with the last beat flag
// carried alongside it.

`timescale 1ns/1ns
`default_nettype none

module slave_mem
	import serial_bus_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  mem_req_t mem_req,
	input  logic     req_valid,
	input  logic     req_last,
	output rd_beat_t rd_beat,
	output logic     beat_valid
);

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic              wr_hit;
	logic              rd_hit;

	assign wr_hit = req_valid && (mem_req.op == OP_WRITE);
	assign rd_hit = req_valid && (mem_req.op == OP_READ);

	// Storage array.
	always_ff @(posedge clk)
	begin
		if (wr_hit)
			mem[mem_req.addr] <= mem_req.data;
	end

	// Read port register. The flag from the receiver rides next to the byte.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_beat    <= '0;
			beat_valid <= 1'b0;
		end
		else
		begin
			beat_valid <= rd_hit;
			if (rd_hit)
			begin
				rd_beat.data <= mem[mem_req.addr];
				rd_beat.last <= req_last;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/slave_in_port.sv
// Serial bus slave receiver.
// Deserializes the request address and write data, keeps the burst beat
// count and the incrementing address, and issues one memory request per beat.
// Read requests are paced on the transmitter busy flag.

`timescale 1ns/1ns
`default_nettype none

module slave_in_port
	import serial_bus_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               master_valid,
	input  logic               read_en,
	input  logic               write_en,
	input  logic [BURST_W-1:0] burst,
	input  logic               rx_address,
	input  logic               rx_data,
	input  logic               out_busy,
	output logic               slave_ready,
	output mem_req_t           mem_req,
	output logic               req_valid,
	output logic               req_last
);

	rx_state_e          state;
	logic [3:0]         bit_cnt;
	logic [BURST_W-1:0] beat_cnt;
	bus_op_e            op_q;
	logic [ADDR_W-1:0]  addr_q;
	logic [DATA_W-1:0]  data_q;
	logic               start;
	logic               beat_start;
	logic               issue;

	// The master may only start something while we are idle or between write beats.
	assign slave_ready = (state == RX_IDLE) || (state == RX_WAIT_BEAT);

	// A request with both or neither enables set is dropped.
	assign start = master_valid && (state == RX_IDLE) && (read_en != write_en);

	// Each further write beat is opened by its own handshake.
	assign beat_start = master_valid && (state == RX_WAIT_BEAT) && write_en && !read_en;

	// Reads after the first one go out as soon as the transmitter is free.
	assign issue = (state == RX_ISSUE) || ((state == RX_WAIT_OUT) && !out_busy);

	assign req_valid = issue;
	assign req_last  = (op_q == OP_READ) && (beat_cnt == '0);
	assign mem_req   = '{op: op_q, addr: addr_q, data: data_q};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			beat_cnt <= '0;
			op_q     <= OP_READ;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					if (start)
					begin
						op_q     <= write_en ? OP_WRITE : OP_READ;
						beat_cnt <= burst;
						bit_cnt  <= 4'd1;
						state    <= RX_ADDR;
					end
				end
				RX_ADDR:
				begin
					if (bit_cnt == 4'(ADDR_W - 1))
					begin
						bit_cnt <= '0;
						state   <= RX_ISSUE;
					end
					else
					begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
				RX_ISSUE:
				begin
					if (beat_cnt == '0)
					begin
						state <= RX_IDLE;
					end
					else
					begin
						beat_cnt <= beat_cnt - 1'b1;
						state    <= (op_q == OP_WRITE) ? RX_WAIT_BEAT : RX_WAIT_OUT;
					end
				end
				RX_WAIT_BEAT:
				begin
					if (beat_start)
					begin
						bit_cnt <= 4'd1;
						state   <= RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (bit_cnt == 4'(DATA_W - 1))
					begin
						bit_cnt <= '0;
						state   <= RX_ISSUE;
					end
					else
					begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
				RX_WAIT_OUT:
				begin
					if (!out_busy)
					begin
						if (beat_cnt == '0)
							state <= RX_IDLE;
						else
							beat_cnt <= beat_cnt - 1'b1;
					end
				end
				default:
				begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// Address and data arrive LSB first. Data bits 1 to 7 of the first beat
	// overlap the address phase.
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			addr_q[0] <= rx_address;
			data_q[0] <= rx_data;
		end
		else if (state == RX_ADDR)
		begin
			addr_q[bit_cnt] <= rx_address;
			if ((op_q == OP_WRITE) && (bit_cnt < 4'(DATA_W)))
				data_q[bit_cnt[2:0]] <= rx_data;
		end
		else if (beat_start)
		begin
			data_q[0] <= rx_data;
		end
		else if (state == RX_DATA)
		begin
			data_q[bit_cnt[2:0]] <= rx_data;
		end
		else if (issue)
		begin
			// Wraps from the top of memory back to zero.
			addr_q <= addr_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/serial_bus_pkg.sv
// Serial bus slave shared definitions.
// Holds the bus widths, the memory depth, the opcode and state encodings,
// and the packed structs passed between the receiver, memory and transmitter.

`default_nettype none

package serial_bus_pkg;

	localparam int ADDR_W    = 12;
	localparam int DATA_W    = 8;
	localparam int BURST_W   = 4;
	localparam int MEM_DEPTH = 1 << ADDR_W;

	// A single bit is enough, since a burst is either all reads or all writes.
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	typedef enum logic [2:0]
	{
		RX_IDLE      = 3'd0,
		RX_ADDR      = 3'd1,
		RX_ISSUE     = 3'd2,
		RX_WAIT_BEAT = 3'd3,
		RX_DATA      = 3'd4,
		RX_WAIT_OUT  = 3'd5
	} rx_state_e;

	typedef enum logic
	{
		TX_IDLE  = 1'b0,
		TX_SHIFT = 1'b1
	} tx_state_e;

	// One memory access from the receiver.
	typedef struct packed
	{
		bus_op_e             op;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   data;
	} mem_req_t;

	// One read byte, with a flag on the final beat of the burst.
	typedef struct packed
	{
		logic [DATA_W-1:0]   data;
		logic                last;
	} rd_beat_t;

endpackage

`default_nettype wire
